// File: include/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// operand and result width
`define ALU_XLEN 32

// op queue entries, also the issue stage credits after reset
`define ALU_FIFO_DEPTH 4

// result credits the sink grants after reset
`define ALU_SINK_CREDITS 2

`endif

// File: rtl/alu_pkg.sv
`include "alu_defs.svh"

package alu_pkg;

  // decoded alu operation
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU
  } alu_op_e;

  // request in the raw ctrl encoding
  typedef struct packed {
    logic [3:0]           ctrl;
    logic                 is_arch;  // picks sra over srl
    logic                 sub;      // picks sub over add
    logic                 sign;     // carried along, op implies it
    logic [`ALU_XLEN-1:0] a;
    logic [`ALU_XLEN-1:0] b;
  } alu_req_t;

  typedef struct packed {
    alu_op_e              op;
    logic [`ALU_XLEN-1:0] a;
    logic [`ALU_XLEN-1:0] b;
  } alu_op_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0] result;
    logic                 zf;
    logic                 of;
    logic                 cf;
    logic                 branch;   // taken, branches only
  } alu_res_t;

endpackage

// File: rtl/alu_issue.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_issue
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  alu_req_t req,
  output logic     req_ready,
  output logic     op_valid,
  output alu_op_t  op,
  input  logic     op_credit
);

  localparam int CW = $clog2(`ALU_FIFO_DEPTH + 1);

  logic [CW-1:0] credits;
  logic          accept;
  alu_op_e       dec_op;

  assign req_ready = (credits != '0);  // one free queue slot is enough
  assign accept    = req_valid && req_ready;

  // raw ctrl to opcode
  always_comb begin
    unique case (req.ctrl)
      4'b0000: dec_op = req.sub ? OP_SUB : OP_ADD;
      4'b0001: dec_op = OP_SLL;
      4'b0010: dec_op = OP_SLT;
      4'b0011: dec_op = OP_SLTU;
      4'b0100: dec_op = OP_XOR;
      4'b0101: dec_op = req.is_arch ? OP_SRA : OP_SRL;
      4'b0110: dec_op = OP_OR;
      4'b0111: dec_op = OP_AND;
      4'b1000: dec_op = OP_BEQ;
      4'b1001: dec_op = OP_BNE;
      4'b1100: dec_op = OP_BLT;
      4'b1101: dec_op = OP_BGE;
      4'b1110: dec_op = OP_BLTU;
      4'b1111: dec_op = OP_BGEU;
      default: dec_op = OP_ADD;  // 1010 and 1011 are reserved
    endcase
  end

  // a credit is spent when the request is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      credits  <= CW'(`ALU_FIFO_DEPTH);
      op_valid <= 1'b0;
    end else begin
      credits  <= credits - CW'(accept) + CW'(op_credit);
      op_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op.op <= dec_op;
      op.a  <= req.a;
      op.b  <= req.b;
    end
  end

endmodule

// File: rtl/alu_op_fifo.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_op_fifo
  import alu_pkg::*;
#(
  parameter int depth = `ALU_FIFO_DEPTH
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    op_valid,
  input  alu_op_t op,
  output logic    op_credit,
  output logic    q_valid,
  output alu_op_t q_op,
  input  logic    q_pop
);

  localparam int PW = (depth > 1) ? $clog2(depth) : 1;
  localparam int CW = $clog2(depth + 1);

  alu_op_t       mem [depth];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  assign q_valid = (count != '0);
  assign q_op    = mem[rd_ptr];  // head entry

  // no full check, the sender holds credits
  always_ff @(posedge clk) begin
    if (op_valid) begin
      mem[wr_ptr] <= op;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      op_credit <= 1'b0;
    end else begin
      if (op_valid) begin
        wr_ptr <= (wr_ptr == PW'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (rd_ptr == PW'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + CW'(op_valid) - CW'(q_pop);
      op_credit <= q_pop;  // slot freed, hand it back
    end
  end

endmodule

// File: rtl/alu_core.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_core
  import alu_pkg::*;
(
  input  alu_op_e              op,
  input  logic [`ALU_XLEN-1:0] a,
  input  logic [`ALU_XLEN-1:0] b,
  output alu_res_t             res
);

  localparam int MSB = `ALU_XLEN - 1;

  logic           sub;
  logic           sign;
  logic [MSB:0]   b_in;
  logic [MSB:0]   sum;
  logic [MSB:0]   shift_res;
  logic [MSB:0]   logic_res;
  logic           cout;
  logic           ovf;
  logic           cmp;

  // compares and branches go through the subtractor
  always_comb begin
    sub  = 1'b0;
    sign = 1'b0;
    unique case (op)
      OP_SUB, OP_SLTU, OP_BEQ, OP_BNE, OP_BLTU, OP_BGEU: sub = 1'b1;
      OP_SLT, OP_BLT, OP_BGE: begin
        sub  = 1'b1;
        sign = 1'b1;
      end
      default: ;
    endcase
  end

  assign b_in        = sub ? ~b : b;
  assign {cout, sum} = {1'b0, a} + {1'b0, b_in} + {{`ALU_XLEN{1'b0}}, sub};

  // overflow from the operand and sum sign bits
  assign ovf = (a[MSB] == b_in[MSB]) && (a[MSB] != sum[MSB]);
  assign cmp = sign ? (ovf ^ sum[MSB]) : ~cout;  // a < b

  always_comb begin
    unique case (op)
      OP_SLL:  shift_res = a << b[4:0];
      OP_SRA:  shift_res = $signed(a) >>> b[4:0];
      default: shift_res = a >> b[4:0];
    endcase
  end

  always_comb begin
    unique case (op)
      OP_XOR:  logic_res = a ^ b;
      OP_OR:   logic_res = a | b;
      default: logic_res = a & b;
    endcase
  end

  always_comb begin
    res.zf     = ~(|sum);
    res.of     = ovf;
    res.cf     = cout;
    res.branch = 1'b0;
    unique case (op)
      OP_SLL, OP_SRL, OP_SRA: res.result = shift_res;
      OP_XOR, OP_OR, OP_AND:  res.result = logic_res;
      OP_ADD, OP_SUB:         res.result = sum;
      default:                res.result = {{MSB{1'b0}}, cmp};  // slt and branches
    endcase
    unique case (op)
      OP_BEQ:          res.branch = ~(|sum);
      OP_BNE:          res.branch = |sum;
      OP_BLT, OP_BLTU: res.branch = cmp;
      OP_BGE, OP_BGEU: res.branch = ~cmp;
      default: ;
    endcase
  end

endmodule

// File: rtl/alu_exec.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_exec
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     q_valid,
  input  alu_op_t  q_op,
  output logic     q_pop,
  output logic     res_valid,
  output alu_res_t res,
  input  logic     res_credit
);

  localparam int CW = $clog2(`ALU_SINK_CREDITS + 1);

  logic [CW-1:0] credits;
  alu_res_t      core_res;

  alu_core core0 (
    .op  (q_op.op),
    .a   (q_op.a),
    .b   (q_op.b),
    .res (core_res)
  );

  // take the head only when the sink can absorb the result
  assign q_pop = q_valid && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      credits   <= CW'(`ALU_SINK_CREDITS);
      res_valid <= 1'b0;
    end else begin
      credits   <= credits - CW'(q_pop) + CW'(res_credit);
      res_valid <= q_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      res <= core_res;  // held until the next pop
    end
  end

endmodule

// File: rtl/alu_top.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_top
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  alu_req_t req,
  output logic     req_ready,
  output logic     res_valid,
  output alu_res_t res,
  input  logic     res_credit
);

  logic    op_valid;
  alu_op_t op;
  logic    op_credit;
  logic    q_valid;
  alu_op_t q_op;
  logic    q_pop;

  alu_issue issue0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .op_valid  (op_valid),
    .op        (op),
    .op_credit (op_credit)
  );

  alu_op_fifo #(
    .depth (`ALU_FIFO_DEPTH)
  ) fifo0 (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op        (op),
    .op_credit (op_credit),
    .q_valid   (q_valid),
    .q_op      (q_op),
    .q_pop     (q_pop)
  );

  alu_exec exec0 (
    .clk        (clk),
    .rst        (rst),
    .q_valid    (q_valid),
    .q_op       (q_op),
    .q_pop      (q_pop),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

endmodule

// File: tb/alu_properties.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_properties #(
  parameter int lw    = 3,
  parameter int limit = 4
) (
  input logic          clk,
  input logic          rst,
  input logic          pop,
  input logic          fire,
  input logic [lw-1:0] level
);

  int fails = 0;  // read by the testbench at the end

  // level is the queue count or the held sink credits
  level_bound: assert property (@(posedge clk) disable iff (rst) int'(level) <= limit)
    else begin
      $error("counter at %0d above limit %0d", level, limit);
      fails++;
    end

  no_empty_pop: assert property (@(posedge clk) disable iff (rst) pop |-> level != '0)
    else begin
      $error("pop with nothing held");
      fails++;
    end

  // credit pulse or result needs something held on the pop edge
  fire_backed: assert property (@(posedge clk) disable iff (rst) fire |-> $past(level) != '0)
    else begin
      $error("output fired with nothing held");
      fails++;
    end

endmodule

bind alu_op_fifo alu_properties #(.lw($bits(count)), .limit(depth)) fifo_props (
  .clk   (clk),
  .rst   (rst),
  .pop   (q_pop),
  .fire  (op_credit),
  .level (count)
);

bind alu_exec alu_properties #(.lw($bits(credits)), .limit(`ALU_SINK_CREDITS)) exec_props (
  .clk   (clk),
  .rst   (rst),
  .pop   (q_pop),
  .fire  (res_valid),
  .level (credits)
);

// File: tb/alu_checker.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_checker
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  input  logic     req_ready,
  input  alu_req_t req,
  input  logic     res_valid,
  input  alu_res_t res,
  input  string    test_name,
  input  logic     lat_check,
  output int       errors,
  output int       checked
);

  alu_res_t exp_q[$];
  string    name_q[$];
  int       edge_q[$];
  int       cyc;
  int       t0;
  string    name;
  alu_res_t exp;

  // expected result worked out from the raw ctrl encoding
  function automatic alu_res_t ref_result(alu_req_t r);
    logic [`ALU_XLEN:0]   s;
    longint               wide;
    logic                 cmp_op;
    logic                 sub;
    logic                 sgn;
    logic                 lt;
    alu_res_t             e;
    cmp_op = (r.ctrl inside {4'b0010, 4'b0011}) || (r.ctrl[3] && r.ctrl[2:1] != 2'b01);
    sub    = cmp_op || (r.ctrl == 4'b0000 && r.sub);
    sgn    = r.ctrl inside {4'b0010, 4'b1100, 4'b1101};
    s      = sub ? {1'b0, r.a} - {1'b0, r.b} : {1'b0, r.a} + {1'b0, r.b};
    wide   = sub ? longint'($signed(r.a)) - longint'($signed(r.b))
                 : longint'($signed(r.a)) + longint'($signed(r.b));
    lt     = sgn ? ($signed(r.a) < $signed(r.b)) : (r.a < r.b);
    e.zf   = (s[`ALU_XLEN-1:0] == '0);
    e.cf   = sub ? !s[`ALU_XLEN] : s[`ALU_XLEN];  // no borrow means carry out
    e.of   = (wide > 64'sh7fffffff) || (wide < -64'sh80000000);
    e.branch = 1'b0;
    case (r.ctrl)
      4'b0000, 4'b1010, 4'b1011: e.result = s[`ALU_XLEN-1:0];  // reserved act as add
      4'b0001: e.result = r.a << r.b[4:0];
      4'b0100: e.result = r.a ^ r.b;
      4'b0110: e.result = r.a | r.b;
      4'b0111: e.result = r.a & r.b;
      4'b0101: begin
        if (r.is_arch) e.result = $signed(r.a) >>> r.b[4:0];
        else e.result = r.a >> r.b[4:0];
      end
      default: e.result = `ALU_XLEN'(lt);  // set-less-than and branches
    endcase
    case (r.ctrl)
      4'b1000: e.branch = (r.a == r.b);
      4'b1001: e.branch = (r.a != r.b);
      4'b1100, 4'b1110: e.branch = lt;
      4'b1101, 4'b1111: e.branch = !lt;
      default: ;
    endcase
    return e;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      cyc     = 0;
      errors  = 0;
      checked = 0;
    end else begin
      cyc++;
      if (res_valid && exp_q.size() == 0) begin
        $display("a result came out with no request outstanding");
        errors++;
      end else if (res_valid) begin
        checked++;
        t0   = edge_q.pop_front();
        name = name_q.pop_front();
        exp  = exp_q.pop_front();
        if (res !== exp) begin
          $display("error %s expected %h actual %h", name, exp, res);
          errors++;
        end
        if (lat_check && cyc - t0 != 3) begin
          $display("error %s expected latency 3 actual %0d", name, cyc - t0);
          errors++;
        end
      end
      if (req_valid && req_ready) begin  // accepting edge
        exp_q.push_back(ref_result(req));
        name_q.push_back(test_name);
        edge_q.push_back(cyc);
      end
    end
  end

endmodule

// File: tb/alu_tb.sv
`timescale 1ns/1ns
`include "alu_defs.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int n_random   = 1000;
  localparam int max_cycles = 2 * (n_random + 1000);  // random mix plus directed and drains
  localparam logic [31:0] edges [4] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff};

  logic        clk;
  logic        rst;
  logic        req_valid;
  alu_req_t    req;
  logic        req_ready;
  logic        res_valid;
  alu_res_t    res;
  logic        res_credit;
  logic        hold;
  logic        lat_check;
  logic        ready_low;
  string       test_name;
  int          seed = 32'h1d95;
  int          sink_seed = 32'h1d95 + 1;  // own stream for the sink
  int          owed;
  int          sent;
  int          cycles;
  int          errors;
  int          checked;
  int          tb_errors;
  int          prop_errors;

  alu_top dut0 (.*);
  alu_checker chk0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // keep valid up until the issue stage takes the request
  task automatic send(input logic [3:0] ctrl, input logic is_arch, input logic sub,
                      input logic [31:0] a, input logic [31:0] b);
    req.ctrl    = ctrl;
    req.is_arch = is_arch;
    req.sub     = sub;
    req.sign    = 1'($random(seed));
    req.a       = a;
    req.b       = b;
    req_valid   = 1'b1;
    while (!req_ready) next_cycle();
    next_cycle();
    req_valid = 1'b0;
    sent++;
  endtask

  task automatic send_random();
    send(4'($random(seed)), 1'($random(seed)), 1'($random(seed)), $random(seed), $random(seed));
  endtask

  task automatic sweep_edges(input logic [3:0] ctrl, input logic sub);
    for (int i = 0; i < 4; i++)
      for (int j = 0; j < 4; j++)
        send(ctrl, 1'b0, sub, edges[i], edges[j]);
  endtask

  // wait for every result and every sink credit to come back
  task automatic drain();
    while (checked != sent || owed != 0) next_cycle();
    repeat (4) next_cycle();
  endtask

  // sink returns credits at random while not held
  always @(posedge clk) begin
    #1;
    if (rst) begin
      owed       = 0;
      res_credit = 1'b0;
    end else begin
      owed       = owed + int'(res_valid);
      res_credit = !hold && owed > 0 && ($random(sink_seed) & 3) != 0;
      if (res_credit) owed = owed - 1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, %0d of %0d results checked", cycles, checked, sent);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    logic [4:0]  amt;
    logic [31:0] sa;
    logic [31:0] sb;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    res_credit = 1'b0;
    hold       = 1'b0;
    lat_check  = 1'b0;
    ready_low  = 1'b0;
    test_name  = "reset";
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    if (!req_ready) begin
      $display("req_ready is low right after reset");
      tb_errors++;
    end

    test_name = "arith";
    sweep_edges(4'b0000, 1'b0);
    sweep_edges(4'b0000, 1'b1);
    sweep_edges(4'b0010, 1'b0);
    sweep_edges(4'b0011, 1'b0);
    sweep_edges(4'b0100, 1'b0);
    sweep_edges(4'b0110, 1'b0);
    sweep_edges(4'b0111, 1'b0);

    test_name = "shift";
    for (int k = 0; k < 8; k++) begin
      amt = (k == 0) ? 5'd0 : (k == 1) ? 5'd1 : (k == 2) ? 5'd31 : 5'($random(seed));
      sb  = {27'($random(seed)), amt};  // upper bits must not matter
      sa  = $random(seed);
      send(4'b0001, 1'b0, 1'b0, sa, sb);
      send(4'b0101, 1'b0, 1'b0, sa, sb);
      send(4'b0101, 1'b1, 1'b0, sa, sb);
    end

    test_name = "branch";  // 1010 and 1011 included
    for (int c = 8; c < 16; c++) sweep_edges(4'(c), 1'b0);
    drain();

    test_name = "backpressure";
    hold = 1'b1;
    fork
      repeat (12) send_random();
      begin
        repeat (50) begin
          next_cycle();
          if (!req_ready) ready_low = 1'b1;
        end
        hold = 1'b0;
      end
    join
    drain();
    if (!ready_low) begin
      $display("req_ready never dropped while the sink held its credits");
      tb_errors++;
    end

    test_name = "random";
    repeat (n_random) begin
      while (($random(seed) & 3) == 0) next_cycle();
      send_random();
    end
    drain();

    test_name = "latency";
    lat_check = 1'b1;
    send_random();
    drain();
    lat_check = 1'b0;

    prop_errors = dut0.fifo0.fifo_props.fails + dut0.exec0.exec_props.fails;
    $display("errors %0d (checker %0d, testbench %0d, assertion %0d), checked %0d of %0d",
             errors + tb_errors + prop_errors, errors, tb_errors, prop_errors, checked, sent);
    if (errors + tb_errors + prop_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: alu_top.f
+incdir+include
rtl/alu_pkg.sv
rtl/alu_issue.sv
rtl/alu_op_fifo.sv
rtl/alu_core.sv
rtl/alu_exec.sv
rtl/alu_top.sv
tb/alu_properties.sv
tb/alu_checker.sv
tb/alu_tb.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = alu_tb
FLIST = alu_top.f
PASS  = all tests passed

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build and run the simulation"
	@echo "make clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
